// ==== files.f ====
fpu_pkg.sv
fpu_align.sv
fpu_mantissa_op.sv
fpu_normalize.sv
fpu_compose.sv
fpu_alu.sv
fpu_alu_chk.sv
tb_fpu_alu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FPU ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu_alu \
        --Mdir obj_dir -f files.f; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_fpu_alu > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation FAILED with exit status $run_status"
    exit 1
fi
echo "Simulation PASSED"
exit 0

// ==== tb_fpu_alu.sv ====
`timescale 1ns/10ps

module tb_fpu_alu;

    typedef struct packed {
        fpu_pkg::alu_op_t  op;
        fpu_pkg::fp_word_t op_a;
        fpu_pkg::fp_word_t op_b;
        fpu_pkg::fp_word_t expected;
    } test_vec_t;

    localparam logic [31:0] lcg_seed     = 32'h773dc3fd;
    localparam int          pipe_depth   = 4;
    localparam int          fill_timeout = 16;
    localparam int          random_count = 40;

    logic              clk;
    logic              rst;
    fpu_pkg::fp_word_t op_a;
    fpu_pkg::fp_word_t op_b;
    fpu_pkg::alu_op_t  op;
    fpu_pkg::fp_word_t result;
    logic              valid;

    test_vec_t         vectors[$];
    test_vec_t         cur;
    fpu_pkg::alu_op_t  cur_op;
    logic [31:0]       lcg_state;
    int                fill_edges;
    logic              verdict_printed;

    fpu_alu UUT (
        .clk    (clk),
        .rst    (rst),
        .op_a   (op_a),
        .op_b   (op_b),
        .op     (op),
        .result (result),
        .valid  (valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ================================================
    // Helpers
    // ================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Signed magnitude mapped onto a two's complement number line, both zeros meet at 0
    function automatic logic signed [32:0] order_key(input fpu_pkg::fp_word_t w);
        logic signed [32:0] mag;
        mag = {2'b00, w[30:0]};
        return w[31] ? -mag : mag;
    endfunction

    // Sign ops and comparisons work on the raw words
    function automatic fpu_pkg::fp_word_t simple_expected(input fpu_pkg::alu_op_t f_op,
                                                          input fpu_pkg::fp_word_t a, b);
        logic same;
        logic less;
        same = order_key(a) == order_key(b);
        less = order_key(a) < order_key(b);
        case (f_op)
            fpu_pkg::op_fneg: return {~a[31], a[30:0]};
            fpu_pkg::op_fabs: return {1'b0, a[30:0]};
            fpu_pkg::op_feq:  return {31'b0, same};
            default:          return {31'b0, less};
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            verdict_printed = 1'b1;
            $display("ERROR at time %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic add_vector(input fpu_pkg::alu_op_t v_op,
                              input fpu_pkg::fp_word_t a, b, expected);
        test_vec_t v;
        v.op       = v_op;
        v.op_a     = a;
        v.op_b     = b;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    task automatic add_random_vectors(input int count);
        fpu_pkg::fp_word_t a;
        fpu_pkg::fp_word_t b;
        logic [31:0]       pick;
        fpu_pkg::alu_op_t  r_op;
        for (int n = 0; n < count; n++) begin
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state;
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state;
            lcg_state = lcg_next(lcg_state);
            pick      = lcg_state;
            // Upper LCG bits are the better mixed ones
            case (pick[31:30])
                2'd0:    r_op = fpu_pkg::op_fneg;
                2'd1:    r_op = fpu_pkg::op_fabs;
                2'd2:    r_op = fpu_pkg::op_feq;
                default: r_op = fpu_pkg::op_fslt;
            endcase
            // Steer some pairs onto equal words, sign flips and signed zeros
            case (pick[29:28])
                2'd1: b = a;
                2'd2: b = {~a[31], a[30:0]};
                2'd3: begin
                    a = {a[31], 31'b0};
                    b = {b[31], 31'b0};
                end
                default: begin
                end
            endcase
            add_vector(r_op, a, b, simple_expected(r_op, a, b));
        end
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        rst             = 1'b1;
        op_a            = '0;
        op_b            = '0;
        op              = fpu_pkg::op_fadd;
        verdict_printed = 1'b0;
        lcg_state       = lcg_seed;

        add_vector(fpu_pkg::op_fadd, 32'h3fc00000, 32'h3fc00000, 32'h40400000);
        add_vector(fpu_pkg::op_fadd, 32'h3f800000, 32'h3e800000, 32'h3fa00000);
        add_vector(fpu_pkg::op_fadd, 32'h40400000, 32'h3f800000, 32'h40800000);
        add_vector(fpu_pkg::op_fadd, 32'h40200000, 32'hc0200000, 32'h00000000);
        add_vector(fpu_pkg::op_fadd, 32'h3f800000, 32'hbe800000, 32'h3f400000);
        add_vector(fpu_pkg::op_fadd, 32'h3f000000, 32'hc0000000, 32'hbfc00000);
        add_vector(fpu_pkg::op_fsub, 32'h40000000, 32'hbf800000, 32'h40400000);
        add_vector(fpu_pkg::op_fsub, 32'h40a00000, 32'h40400000, 32'h40000000);
        add_vector(fpu_pkg::op_fmul, 32'h3fc00000, 32'h40000000, 32'h40400000);
        add_vector(fpu_pkg::op_fmul, 32'hc0000000, 32'h40400000, 32'hc0c00000);
        add_vector(fpu_pkg::op_fmul, 32'h3fc00000, 32'h3fc00000, 32'h40100000);
        // Tie with an odd LSB rounds up
        add_vector(fpu_pkg::op_fmul, 32'h3f800001, 32'h3fc00000, 32'h3fc00002);
        add_vector(fpu_pkg::op_fmul, 32'h71800000, 32'hf1800000, 32'hff800000);
        add_vector(fpu_pkg::op_fmul, 32'h0d800000, 32'h8d800000, 32'h80000000);
        add_vector(fpu_pkg::op_fneg, 32'h3f800000, 32'h00000000, 32'hbf800000);
        add_vector(fpu_pkg::op_fneg, 32'h00000000, 32'h00000000, 32'h80000000);
        add_vector(fpu_pkg::op_fabs, 32'hc0400000, 32'h00000000, 32'h40400000);
        add_vector(fpu_pkg::op_feq,  32'h00000000, 32'h80000000, 32'h00000001);
        add_vector(fpu_pkg::op_feq,  32'h3f800000, 32'h3f800000, 32'h00000001);
        add_vector(fpu_pkg::op_feq,  32'h3f800000, 32'hbf800000, 32'h00000000);
        add_vector(fpu_pkg::op_fslt, 32'h80000000, 32'h00000000, 32'h00000000);
        add_vector(fpu_pkg::op_fslt, 32'hbf800000, 32'h3f800000, 32'h00000001);
        add_vector(fpu_pkg::op_fslt, 32'h3f800000, 32'hbf800000, 32'h00000000);
        add_vector(fpu_pkg::op_fslt, 32'hc0000000, 32'hbf800000, 32'h00000001);
        add_vector(fpu_pkg::op_fslt, 32'hbf800000, 32'hc0000000, 32'h00000000);
        add_vector(fpu_pkg::op_fslt, 32'h3f800000, 32'h40000000, 32'h00000001);
        add_vector(fpu_pkg::op_fslt, 32'h40000000, 32'h40000000, 32'h00000000);
        add_random_vectors(random_count);

        // Reset held for four edges and released on the last one
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            if (c == 3)
                rst <= 1'b0;
            @(negedge clk);
            check_value(32'(valid), 32'd0, "valid during reset");
        end

        fill_edges = 0;
        while (!valid && fill_edges < fill_timeout) begin
            @(posedge clk);
            fill_edges++;
            @(negedge clk);
        end
        if (!valid) begin
            verdict_printed = 1'b1;
            $display("Timeout: valid did not rise within %0d cycles after reset", fill_timeout);
            $display("Test failures found");
            $fatal(1, "Stopped on timeout");
        end
        check_value(fill_edges, pipe_depth, "edges from reset release until valid");

        // Back-to-back issue with each result checked four edges after its inputs
        for (int i = 0; i < vectors.size() + pipe_depth; i++) begin
            @(posedge clk);
            if (i < vectors.size()) begin
                op   <= vectors[i].op;
                op_a <= vectors[i].op_a;
                op_b <= vectors[i].op_b;
            end else begin
                op   <= fpu_pkg::op_fadd;
                op_a <= '0;
                op_b <= '0;
            end
            @(negedge clk);
            check_value(32'(valid), 32'd1, "valid while pipeline runs");
            if (i >= pipe_depth) begin
                cur    = vectors[i - pipe_depth];
                cur_op = cur.op;
                check_value(result, cur.expected,
                            $sformatf("vector %0d %s a=%h b=%h", i - pipe_depth,
                                      cur_op.name(), cur.op_a, cur.op_b));
            end
        end

        verdict_printed = 1'b1;
        $display("All tests passed!");
        $finish;
    end

    final begin
        if (!verdict_printed) begin
            $display("Simulation ended before the test sequence completed");
            $display("Test failures found");
        end
    end

endmodule

// ==== fpu_alu_chk.sv ====
`timescale 1ns/10ps

module fpu_alu_chk (
    input logic              clk,
    input logic              rst,
    input fpu_pkg::alu_op_t  op,
    input fpu_pkg::fp_word_t result,
    input logic              valid
);

    // Output stage clears on the edge that samples reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !valid)
        else $error("valid high in the cycle after reset");

    compare_is_boolean: assert property (@(posedge clk) disable iff (rst)
        (op == fpu_pkg::op_feq || op == fpu_pkg::op_fslt) |-> (result[31:1] == '0))
        else $error("comparison result is neither 0 nor 1");

    abs_sign_clear: assert property (@(posedge clk) disable iff (rst)
        (op == fpu_pkg::op_fabs) |-> !result[31])
        else $error("absolute value result has its sign bit set");

endmodule

bind fpu_compose fpu_alu_chk u_chk (
    .clk    (clk),
    .rst    (rst),
    .op     (s_q.op),
    .result (result),
    .valid  (valid)
);

// ==== fpu_alu.sv ====
`timescale 1ns/10ps

module fpu_alu (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::fp_word_t op_a,
    input  fpu_pkg::fp_word_t op_b,
    input  fpu_pkg::alu_op_t  op,
    output fpu_pkg::fp_word_t result,
    output logic              valid
);

    fpu_pkg::align_t align_s;
    fpu_pkg::arith_t arith_s;
    fpu_pkg::norm_t  norm_s;
    logic            align_valid;
    logic            arith_valid;
    logic            norm_valid;

    // Four register stages, result valid three edges after stage 1 capture
    fpu_align u_align (
        .clk       (clk),
        .rst       (rst),
        .op_a      (op_a),
        .op_b      (op_b),
        .op        (op),
        .stage_out (align_s),
        .valid_out (align_valid)
    );

    fpu_mantissa_op u_mantissa_op (
        .clk       (clk),
        .rst       (rst),
        .stage_in  (align_s),
        .valid_in  (align_valid),
        .stage_out (arith_s),
        .valid_out (arith_valid)
    );

    fpu_normalize u_normalize (
        .clk       (clk),
        .rst       (rst),
        .stage_in  (arith_s),
        .valid_in  (arith_valid),
        .stage_out (norm_s),
        .valid_out (norm_valid)
    );

    fpu_compose u_compose (
        .clk      (clk),
        .rst      (rst),
        .stage_in (norm_s),
        .valid_in (norm_valid),
        .result   (result),
        .valid    (valid)
    );

endmodule

// ==== fpu_compose.sv ====
`timescale 1ns/10ps

module fpu_compose (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::norm_t    stage_in,
    input  logic              valid_in,
    output fpu_pkg::fp_word_t result,
    output logic              valid
);

    fpu_pkg::norm_t                                  s_q;
    logic                                            valid_q;
    fpu_pkg::sum_t                                   sig_rnd;
    logic [fpu_pkg::exp_w:0]                         exp_rnd;
    logic [fpu_pkg::frac_w-1:0]                      frac;
    fpu_pkg::fp_word_t                               arith_word;
    logic                                            sign_a;
    logic                                            sign_b;
    logic [fpu_pkg::exp_w+fpu_pkg::frac_w-1:0]       mag_a;
    logic [fpu_pkg::exp_w+fpu_pkg::frac_w-1:0]       mag_b;
    logic                                            both_zero;
    logic                                            a_less;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_q     <= '0;
            s_q.op  <= fpu_pkg::op_fadd;
            valid_q <= 1'b0;
        end else begin
            s_q     <= stage_in;
            valid_q <= valid_in;
        end
    end

    // ================================================
    // Rounding and range limits
    // ================================================
    always_comb begin
        sig_rnd = {1'b0, s_q.sig} + fpu_pkg::sum_t'(s_q.round_up);
        if (sig_rnd[fpu_pkg::sig_w]) begin
            // Carry out of the significand, renormalize
            exp_rnd = {1'b0, s_q.exp} + 1'b1;
            frac    = sig_rnd[fpu_pkg::sig_w-1:1];
        end else begin
            exp_rnd = {1'b0, s_q.exp};
            frac    = sig_rnd[fpu_pkg::frac_w-1:0];
        end

        if (exp_rnd >= fpu_pkg::exp_max) begin
            arith_word = {s_q.sign, {fpu_pkg::exp_w{1'b1}}, {fpu_pkg::frac_w{1'b0}}};
        end else if (exp_rnd == '0) begin
            arith_word = {s_q.sign, {(fpu_pkg::exp_w + fpu_pkg::frac_w){1'b0}}};
        end else begin
            arith_word = {s_q.sign, exp_rnd[fpu_pkg::exp_w-1:0], frac};
        end
    end

    // ================================================
    // Sign ops and comparisons on the raw words
    // ================================================
    assign {sign_a, mag_a} = s_q.op_a;
    assign {sign_b, mag_b} = s_q.op_b;
    assign both_zero = (mag_a == '0) && (mag_b == '0);

    always_comb begin
        if (sign_a != sign_b) begin
            a_less = sign_a;
        end else if (!sign_a) begin
            a_less = mag_a < mag_b;
        end else begin
            a_less = mag_a > mag_b;
        end
    end

    always_comb begin
        case (s_q.op)
            fpu_pkg::op_fadd, fpu_pkg::op_fsub, fpu_pkg::op_fmul: result = arith_word;
            fpu_pkg::op_fneg: result = {~sign_a, mag_a};
            fpu_pkg::op_fabs: result = {1'b0, mag_a};
            // +0 and -0 compare equal
            fpu_pkg::op_feq:  result = fpu_pkg::fp_word_t'(both_zero || (s_q.op_a == s_q.op_b));
            fpu_pkg::op_fslt: result = fpu_pkg::fp_word_t'(a_less && !both_zero);
            default:          result = '0;
        endcase
    end

    assign valid = valid_q;

endmodule

// ==== fpu_normalize.sv ====
`timescale 1ns/10ps

module fpu_normalize (
    input  logic            clk,
    input  logic            rst,
    input  fpu_pkg::arith_t stage_in,
    input  logic            valid_in,
    output fpu_pkg::norm_t  stage_out,
    output logic            valid_out
);

    fpu_pkg::arith_t s_q;
    logic            valid_q;
    int              lead_pos;
    int              shift;
    fpu_pkg::sum_t   norm_sum;
    logic            guard;
    logic            rnd;
    logic            sticky;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_q     <= '0;
            s_q.op  <= fpu_pkg::op_fadd;
            valid_q <= 1'b0;
        end else begin
            s_q     <= stage_in;
            valid_q <= valid_in;
        end
    end

    // Leading-one search below the carry bit
    always_comb begin
        lead_pos = 0;
        for (int i = 0; i < fpu_pkg::sig_w; i++) begin
            if (s_q.sum[i]) begin
                lead_pos = i;
            end
        end
        shift    = fpu_pkg::sig_w - 1 - lead_pos;
        norm_sum = s_q.sum << shift;
    end

    always_comb begin
        stage_out.op   = s_q.op;
        stage_out.op_a = s_q.op_a;
        stage_out.op_b = s_q.op_b;
        stage_out.sig  = '0;
        stage_out.exp  = '0;
        stage_out.sign = 1'b0;
        guard          = 1'b0;
        rnd            = 1'b0;
        sticky         = 1'b0;

        case (s_q.op)
            fpu_pkg::op_fadd, fpu_pkg::op_fsub: begin
                if (s_q.sum == '0) begin
                    // Exact cancellation gives +0
                    stage_out.sign = 1'b0;
                end else if (s_q.sum[fpu_pkg::sig_w]) begin
                    stage_out.sig  = s_q.sum[fpu_pkg::sig_w:1];
                    stage_out.exp  = s_q.exp + fpu_pkg::exp_t'(1);
                    stage_out.sign = s_q.sign;
                end else if (shift <= int'(s_q.exp)) begin
                    stage_out.sig  = norm_sum[fpu_pkg::sig_w-1:0];
                    stage_out.exp  = s_q.exp - fpu_pkg::exp_t'(shift);
                    stage_out.sign = s_q.sign;
                end
                // otherwise underflow, flushed to +0 by the defaults
            end
            fpu_pkg::op_fmul: begin
                stage_out.sign = s_q.sign;
                stage_out.exp  = s_q.exp;
                if (s_q.prod[2*fpu_pkg::sig_w-1]) begin
                    // Product in [2,4), window one bit higher
                    stage_out.sig = s_q.prod[2*fpu_pkg::sig_w-1 -: fpu_pkg::sig_w];
                    guard         = s_q.prod[fpu_pkg::sig_w-1];
                    rnd           = s_q.prod[fpu_pkg::sig_w-2];
                    sticky        = |s_q.prod[fpu_pkg::sig_w-3:0];
                    // Saturated exponents stay pinned
                    if (s_q.exp != '0 && s_q.exp != fpu_pkg::exp_t'(fpu_pkg::exp_max)) begin
                        stage_out.exp = s_q.exp + fpu_pkg::exp_t'(1);
                    end
                end else begin
                    stage_out.sig = s_q.prod[2*fpu_pkg::sig_w-2 -: fpu_pkg::sig_w];
                    guard         = s_q.prod[fpu_pkg::sig_w-2];
                    rnd           = s_q.prod[fpu_pkg::sig_w-3];
                    sticky        = |s_q.prod[fpu_pkg::sig_w-4:0];
                end
            end
            default: begin
                stage_out.sign = 1'b0;
            end
        endcase

        // Nearest-even, zero for add and subtract
        stage_out.round_up = guard & (rnd | sticky | stage_out.sig[0]);
    end

    assign valid_out = valid_q;

endmodule

// ==== fpu_mantissa_op.sv ====
`timescale 1ns/10ps

module fpu_mantissa_op (
    input  logic            clk,
    input  logic            rst,
    input  fpu_pkg::align_t stage_in,
    input  logic            valid_in,
    output fpu_pkg::arith_t stage_out,
    output logic            valid_out
);

    fpu_pkg::align_t s_q;
    logic            valid_q;
    fpu_pkg::sum_t   mag_a;
    fpu_pkg::sum_t   mag_b;
    int              mul_exp;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_q     <= '0;
            s_q.op  <= fpu_pkg::op_fadd;
            valid_q <= 1'b0;
        end else begin
            s_q     <= stage_in;
            valid_q <= valid_in;
        end
    end

    always_comb begin
        // Smaller operand shifted right, bits that fall off are dropped
        if (s_q.a_larger) begin
            mag_a = {1'b0, s_q.sig_a};
            mag_b = {1'b0, s_q.sig_b} >> s_q.exp_diff;
        end else begin
            mag_a = {1'b0, s_q.sig_a} >> s_q.exp_diff;
            mag_b = {1'b0, s_q.sig_b};
        end

        mul_exp = int'(s_q.exp_a) + int'(s_q.exp_b) - fpu_pkg::exp_bias;

        stage_out.op   = s_q.op;
        stage_out.op_a = s_q.op_a;
        stage_out.op_b = s_q.op_b;
        stage_out.sum  = '0;
        stage_out.prod = '0;
        stage_out.exp  = '0;
        stage_out.sign = 1'b0;

        case (s_q.op)
            fpu_pkg::op_fadd, fpu_pkg::op_fsub: begin
                if (s_q.sign_a == s_q.sign_b) begin
                    stage_out.sum  = mag_a + mag_b;
                    stage_out.sign = s_q.sign_a;
                end else if (mag_a >= mag_b) begin
                    stage_out.sum  = mag_a - mag_b;
                    stage_out.sign = s_q.sign_a;
                end else begin
                    stage_out.sum  = mag_b - mag_a;
                    stage_out.sign = s_q.sign_b;
                end
                stage_out.exp = s_q.aligned_exp;
            end
            fpu_pkg::op_fmul: begin
                stage_out.prod = fpu_pkg::prod_t'(s_q.sig_a) * fpu_pkg::prod_t'(s_q.sig_b);
                stage_out.sign = s_q.sign_a ^ s_q.sign_b;
                // Clamp so the 8-bit exponent cannot wrap
                if (mul_exp <= 0) begin
                    stage_out.exp = '0;
                end else if (mul_exp >= fpu_pkg::exp_max) begin
                    stage_out.exp = fpu_pkg::exp_t'(fpu_pkg::exp_max);
                end else begin
                    stage_out.exp = fpu_pkg::exp_t'(mul_exp);
                end
            end
            default: begin
                stage_out.sign = 1'b0;
            end
        endcase
    end

    assign valid_out = valid_q;

endmodule

// ==== fpu_align.sv ====
`timescale 1ns/10ps

module fpu_align (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::fp_word_t op_a,
    input  fpu_pkg::fp_word_t op_b,
    input  fpu_pkg::alu_op_t  op,
    output fpu_pkg::align_t   stage_out,
    output logic              valid_out
);

    fpu_pkg::fp_word_t op_a_q;
    fpu_pkg::fp_word_t op_b_q;
    fpu_pkg::alu_op_t  op_q;
    logic              valid_q;
    fpu_pkg::exp_t     exp_a;
    fpu_pkg::exp_t     exp_b;

    // Operand capture, one new operation per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            op_a_q  <= '0;
            op_b_q  <= '0;
            op_q    <= fpu_pkg::op_fadd;
            valid_q <= 1'b0;
        end else begin
            op_a_q  <= op_a;
            op_b_q  <= op_b;
            op_q    <= op;
            valid_q <= 1'b1;
        end
    end

    assign exp_a = op_a_q[fpu_pkg::frac_w +: fpu_pkg::exp_w];
    assign exp_b = op_b_q[fpu_pkg::frac_w +: fpu_pkg::exp_w];

    always_comb begin
        stage_out.op     = op_q;
        stage_out.op_a   = op_a_q;
        stage_out.op_b   = op_b_q;
        stage_out.sign_a = op_a_q[fpu_pkg::exp_w + fpu_pkg::frac_w];
        // subtract is handled as add with b negated
        stage_out.sign_b = op_b_q[fpu_pkg::exp_w + fpu_pkg::frac_w] ^ (op_q == fpu_pkg::op_fsub);
        stage_out.exp_a  = exp_a;
        stage_out.exp_b  = exp_b;
        // Hidden one always inserted
        stage_out.sig_a  = {1'b1, op_a_q[fpu_pkg::frac_w-1:0]};
        stage_out.sig_b  = {1'b1, op_b_q[fpu_pkg::frac_w-1:0]};

        // Larger exponent sets the result scale
        if (exp_a >= exp_b) begin
            stage_out.exp_diff    = exp_a - exp_b;
            stage_out.a_larger    = 1'b1;
            stage_out.aligned_exp = exp_a;
        end else begin
            stage_out.exp_diff    = exp_b - exp_a;
            stage_out.a_larger    = 1'b0;
            stage_out.aligned_exp = exp_b;
        end
    end

    assign valid_out = valid_q;

endmodule

// ==== fpu_pkg.sv ====
package fpu_pkg;

    // ================================================
    // Field widths and encoding constants
    // ================================================
    localparam int exp_w    = 8;
    localparam int frac_w   = 23;
    localparam int sig_w    = 24;
    localparam int exp_bias = 127;
    localparam int exp_max  = 255;

    // Single-precision word and its parts
    typedef logic [exp_w+frac_w:0] fp_word_t;
    typedef logic [exp_w-1:0]      exp_t;
    typedef logic [sig_w-1:0]      sig_t;

    // Sum keeps one carry bit above the significand
    typedef logic [sig_w:0]        sum_t;
    typedef logic [2*sig_w-1:0]    prod_t;

    typedef enum logic [2:0] {
        op_fadd = 3'd0,
        op_fsub = 3'd1,
        op_fmul = 3'd2,
        op_fneg = 3'd3,
        op_fabs = 3'd4,
        op_feq  = 3'd5,
        op_fslt = 3'd6
    } alu_op_t;

    // ================================================
    // Stage payloads
    // ================================================

    // Sign of b is already inverted for subtract
    typedef struct packed {
        alu_op_t  op;
        fp_word_t op_a;
        fp_word_t op_b;
        logic     sign_a;
        logic     sign_b;
        exp_t     exp_a;
        exp_t     exp_b;
        sig_t     sig_a;
        sig_t     sig_b;
        exp_t     exp_diff;
        logic     a_larger;
        exp_t     aligned_exp;
    } align_t;

    typedef struct packed {
        alu_op_t  op;
        fp_word_t op_a;
        fp_word_t op_b;
        sum_t     sum;
        prod_t    prod;
        exp_t     exp;
        logic     sign;
    } arith_t;

    typedef struct packed {
        alu_op_t  op;
        fp_word_t op_a;
        fp_word_t op_b;
        sig_t     sig;
        exp_t     exp;
        logic     sign;
        logic     round_up;
    } norm_t;

endpackage
